// ==== design/keyPkg.sv ====
`default_nettype none

package keyPkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////

	localparam int numButtons = 6;

	typedef logic [7:0]            keyCode_t;
	typedef logic [2:0]            buttonIndex_t;
	typedef logic [numButtons-1:0] buttonMask_t;
	typedef logic [15:0]           holdCount_t;
	typedef logic [7:0]            errorCount_t;

	// Prefix tracking in the scan-code decoder
	typedef enum logic [1:0] {
		stIdle,
		stExtended,
		stRelease,
		stExtendedRelease
	} decoderState_t;

	//////////////////////////////////////////////////
	// Button numbering and set-2 codes
	//////////////////////////////////////////////////

	localparam buttonIndex_t btnUp    = 3'd0;
	localparam buttonIndex_t btnDown  = 3'd1;
	localparam buttonIndex_t btnLeft  = 3'd2;
	localparam buttonIndex_t btnRight = 3'd3;
	localparam buttonIndex_t btnA     = 3'd4;
	localparam buttonIndex_t btnB     = 3'd5;

	// Arrows, only behind E0
	localparam keyCode_t codeUp    = 8'h75;
	localparam keyCode_t codeDown  = 8'h72;
	localparam keyCode_t codeLeft  = 8'h6B;
	localparam keyCode_t codeRight = 8'h74;

	// Plain keys, only without E0
	localparam keyCode_t codeA = 8'h1C;
	localparam keyCode_t codeB = 8'h32;

	localparam keyCode_t codeRelease  = 8'hF0;
	localparam keyCode_t codeExtended = 8'hE0;

	localparam holdCount_t holdCountMax = '1;

endpackage

`default_nettype wire

// ==== design/ps2FrameReceiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module ps2FrameReceiver (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire logic       ps2Clk,
	input  wire logic       ps2Data,
	output logic            byteValid,
	output keyPkg::keyCode_t rxByte,
	output logic            frameError
);

	//////////////////////////////////////////////////
	// Line synchronizers and edge detect
	//////////////////////////////////////////////////

	logic [1:0] clkSync;
	logic [1:0] dataSync;
	logic       clkPrev;
	logic       fallEdge;

	// Both lines idle high, so no false edge leaving reset
	always_ff @(posedge clk) begin
		if (rst) begin
			clkSync  <= 2'b11;
			dataSync <= 2'b11;
			clkPrev  <= 1'b1;
		end else begin
			clkSync  <= {clkSync[0], ps2Clk};
			dataSync <= {dataSync[0], ps2Data};
			clkPrev  <= clkSync[1];
		end
	end

	assign fallEdge = clkPrev & ~clkSync[1];

	//////////////////////////////////////////////////
	// Frame shifting
	//////////////////////////////////////////////////

	logic [3:0]  bitCount;
	logic [9:0]  shiftReg;
	logic [10:0] frame;
	logic        frameDone;
	logic        startOk;
	logic        parityOk;
	logic        stopOk;
	logic        frameOk;

	// Bit count runs 0..10, one step per falling edge
	always_ff @(posedge clk) begin
		if (rst) begin
			bitCount <= '0;
		end else if (fallEdge) begin
			if (bitCount == 4'd10) begin
				bitCount <= '0;
			end else begin
				bitCount <= bitCount + 4'd1;
			end
		end
	end

	// LSB first, new bits enter at the top
	always_ff @(posedge clk) begin
		if (fallEdge) begin
			shiftReg <= {dataSync[1], shiftReg[9:1]};
		end
	end

	// Stop bit taken straight from the line on the last edge
	assign frame     = {dataSync[1], shiftReg};
	assign frameDone = fallEdge && (bitCount == 4'd10);

	assign startOk  = ~frame[0];
	assign parityOk = ^frame[9:1];  // odd parity over data plus parity bit
	assign stopOk   = frame[10];
	assign frameOk  = startOk && parityOk && stopOk;

	//////////////////////////////////////////////////
	// Result strobes
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			byteValid  <= 1'b0;
			frameError <= 1'b0;
		end else begin
			byteValid  <= frameDone && frameOk;
			frameError <= frameDone && !frameOk;
		end
	end

	always_ff @(posedge clk) begin
		if (frameDone) begin
			rxByte <= frame[8:1];
		end
	end

	// One verdict per frame
	assert property (@(posedge clk) disable iff (rst) !(byteValid && frameError));

endmodule

`default_nettype wire

// ==== design/scanCodeDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module scanCodeDecoder (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              byteValid,
	input  wire keyPkg::keyCode_t  rxByte,
	output logic                   keyStrobe,
	output keyPkg::buttonIndex_t   keyIndex,
	output logic                   keyPressed
);

	import keyPkg::*;

	decoderState_t state;
	logic          extendedSeen;
	logic          releaseSeen;
	logic          codeHit;
	buttonIndex_t  codeIndex;

	assign extendedSeen = (state == stExtended) || (state == stExtendedRelease);
	assign releaseSeen  = (state == stRelease) || (state == stExtendedRelease);

	//////////////////////////////////////////////////
	// Code table
	//////////////////////////////////////////////////

	// Arrows only count behind E0, A and B only without it
	always_comb begin
		codeHit   = 1'b1;
		codeIndex = btnUp;
		if (extendedSeen) begin
			case (rxByte)
				codeUp:    codeIndex = btnUp;
				codeDown:  codeIndex = btnDown;
				codeLeft:  codeIndex = btnLeft;
				codeRight: codeIndex = btnRight;
				default:   codeHit   = 1'b0;
			endcase
		end else begin
			case (rxByte)
				codeA:   codeIndex = btnA;
				codeB:   codeIndex = btnB;
				default: codeHit   = 1'b0;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Prefix FSM
	//////////////////////////////////////////////////

	// E0 always restarts a sequence, F0 keeps the extended flag
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stIdle;
		end else if (byteValid) begin
			case (rxByte)
				codeExtended: state <= stExtended;
				codeRelease:  state <= extendedSeen ? stExtendedRelease : stRelease;
				default:      state <= stIdle;
			endcase
		end
	end

	// Prefix bytes never hit the table, so no extra check here
	always_ff @(posedge clk) begin
		if (rst) begin
			keyStrobe <= 1'b0;
		end else begin
			keyStrobe <= byteValid && codeHit;
		end
	end

	always_ff @(posedge clk) begin
		if (byteValid) begin
			keyIndex   <= codeIndex;
			keyPressed <= !releaseSeen;
		end
	end

	// Downstream indexes a six-entry mask with keyIndex
	assert property (@(posedge clk) disable iff (rst)
		keyStrobe |-> (keyIndex < numButtons));

endmodule

`default_nettype wire

// ==== design/holdTimeCounters.sv ====
`timescale 1ns/1ps
`default_nettype none

module holdTimeCounters (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 keyStrobe,
	input  wire keyPkg::buttonIndex_t keyIndex,
	input  wire logic                 keyPressed,
	input  wire logic                 holdTick,
	input  wire logic                 counterClear,
	output keyPkg::buttonMask_t       heldMask,
	output keyPkg::holdCount_t        countUp,
	output keyPkg::holdCount_t        countDown,
	output keyPkg::holdCount_t        countLeft,
	output keyPkg::holdCount_t        countRight,
	output keyPkg::holdCount_t        countA,
	output keyPkg::holdCount_t        countB
);

	import keyPkg::*;

	holdCount_t counts [numButtons];

	//////////////////////////////////////////////////
	// Held state
	//////////////////////////////////////////////////

	// Repeats from typematic just rewrite the same bit
	always_ff @(posedge clk) begin
		if (rst) begin
			heldMask <= '0;
		end else if (keyStrobe) begin
			heldMask[keyIndex] <= keyPressed;
		end
	end

	//////////////////////////////////////////////////
	// Saturating counters
	//////////////////////////////////////////////////

	// Clear beats tick, mask untouched by clear
	always_ff @(posedge clk) begin
		if (rst || counterClear) begin
			for (int i = 0; i < numButtons; i++) begin
				counts[i] <= '0;
			end
		end else if (holdTick) begin
			for (int i = 0; i < numButtons; i++) begin
				if (heldMask[i] && (counts[i] != holdCountMax)) begin
					counts[i] <= counts[i] + 1'b1;
				end
			end
		end
	end

	assign countUp    = counts[btnUp];
	assign countDown  = counts[btnDown];
	assign countLeft  = counts[btnLeft];
	assign countRight = counts[btnRight];
	assign countA     = counts[btnA];
	assign countB     = counts[btnB];

	// Counts only move up between clears, saturation included
	for (genvar g = 0; g < numButtons; g++) begin : noDecrease
		assert property (@(posedge clk) disable iff (rst)
			!counterClear |=> (counts[g] >= $past(counts[g])));
	end

endmodule

`default_nettype wire

// ==== design/holdReadout.sv ====
`timescale 1ns/1ps
`default_nettype none

module holdReadout (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire keyPkg::buttonIndex_t readSel,
	input  wire keyPkg::holdCount_t   countUp,
	input  wire keyPkg::holdCount_t   countDown,
	input  wire keyPkg::holdCount_t   countLeft,
	input  wire keyPkg::holdCount_t   countRight,
	input  wire keyPkg::holdCount_t   countA,
	input  wire keyPkg::holdCount_t   countB,
	input  wire logic                 keyStrobe,
	input  wire keyPkg::buttonIndex_t keyIndex,
	input  wire logic                 keyPressed,
	input  wire logic                 frameError,
	output keyPkg::holdCount_t        readCount,
	output logic                      releaseStrobe,
	output keyPkg::buttonIndex_t      releaseIndex,
	output keyPkg::holdCount_t        releaseHold,
	output keyPkg::errorCount_t       frameErrors
);

	import keyPkg::*;

	holdCount_t countTable [numButtons];
	holdCount_t selCount;
	holdCount_t keyCount;

	assign countTable[btnUp]    = countUp;
	assign countTable[btnDown]  = countDown;
	assign countTable[btnLeft]  = countLeft;
	assign countTable[btnRight] = countRight;
	assign countTable[btnA]     = countA;
	assign countTable[btnB]     = countB;

	// Selects 6 and 7 read as zero
	assign selCount = (readSel < numButtons) ? countTable[readSel] : '0;
	assign keyCount = (keyIndex < numButtons) ? countTable[keyIndex] : '0;

	//////////////////////////////////////////////////
	// Strobes and error count
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			releaseStrobe <= 1'b0;
			frameErrors   <= '0;
		end else begin
			releaseStrobe <= keyStrobe && !keyPressed;
			if (frameError && !(&frameErrors)) begin
				frameErrors <= frameErrors + 1'b1;
			end
		end
	end

	// Report carries the count seen in the event cycle
	always_ff @(posedge clk) begin
		readCount <= selCount;
		if (keyStrobe) begin
			releaseIndex <= keyIndex;
			releaseHold  <= keyCount;
		end
	end

endmodule

`default_nettype wire

// ==== design/keypadTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module keypadTop (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 ps2Clk,
	input  wire logic                 ps2Data,
	input  wire logic                 holdTick,
	input  wire logic                 counterClear,
	input  wire keyPkg::buttonIndex_t readSel,
	output keyPkg::holdCount_t        readCount,
	output keyPkg::buttonMask_t       heldMask,
	output logic                      releaseStrobe,
	output keyPkg::buttonIndex_t      releaseIndex,
	output keyPkg::holdCount_t        releaseHold,
	output keyPkg::errorCount_t       frameErrors
);

	import keyPkg::*;

	// Receiver outputs
	logic         byteValid;
	logic         frameError;
	keyCode_t     rxByte;

	// Key events
	logic         keyStrobe;
	logic         keyPressed;
	buttonIndex_t keyIndex;

	holdCount_t   countUp;
	holdCount_t   countDown;
	holdCount_t   countLeft;
	holdCount_t   countRight;
	holdCount_t   countA;
	holdCount_t   countB;

	ps2FrameReceiver receiver (
		.clk        (clk),
		.rst        (rst),
		.ps2Clk     (ps2Clk),
		.ps2Data    (ps2Data),
		.byteValid  (byteValid),
		.rxByte     (rxByte),
		.frameError (frameError)
	);

	scanCodeDecoder decoder (
		.clk        (clk),
		.rst        (rst),
		.byteValid  (byteValid),
		.rxByte     (rxByte),
		.keyStrobe  (keyStrobe),
		.keyIndex   (keyIndex),
		.keyPressed (keyPressed)
	);

	holdTimeCounters counters (
		.clk          (clk),
		.rst          (rst),
		.keyStrobe    (keyStrobe),
		.keyIndex     (keyIndex),
		.keyPressed   (keyPressed),
		.holdTick     (holdTick),
		.counterClear (counterClear),
		.heldMask     (heldMask),
		.countUp      (countUp),
		.countDown    (countDown),
		.countLeft    (countLeft),
		.countRight   (countRight),
		.countA       (countA),
		.countB       (countB)
	);

	holdReadout readout (
		.clk           (clk),
		.rst           (rst),
		.readSel       (readSel),
		.countUp       (countUp),
		.countDown     (countDown),
		.countLeft     (countLeft),
		.countRight    (countRight),
		.countA        (countA),
		.countB        (countB),
		.keyStrobe     (keyStrobe),
		.keyIndex      (keyIndex),
		.keyPressed    (keyPressed),
		.frameError    (frameError),
		.readCount     (readCount),
		.releaseStrobe (releaseStrobe),
		.releaseIndex  (releaseIndex),
		.releaseHold   (releaseHold),
		.frameErrors   (frameErrors)
	);

endmodule

`default_nettype wire

// ==== bench/ps2KeyStimulus.svh ====
// Keyboard side of the PS/2 link, included inside the testbench module.
// Expects clk, ps2Clk and ps2Data to be declared before the include.

// Set-2 make code for each button
function automatic keyCode_t buttonCode(input buttonIndex_t idx);
	case (idx)
		btnUp:    return codeUp;
		btnDown:  return codeDown;
		btnLeft:  return codeLeft;
		btnRight: return codeRight;
		btnA:     return codeA;
		default:  return codeB;
	endcase
endfunction

// Arrows live behind E0
function automatic bit isArrow(input buttonIndex_t idx);
	return (idx != btnA) && (idx != btnB);
endfunction

// One 11-bit frame, 20 system clocks per bit, data set while clock is high
task automatic sendFrame(input keyCode_t code, input logic parityFault);
	logic [10:0] bits;
	bits = {1'b1, ~(^code) ^ parityFault, code, 1'b0};
	for (int i = 0; i < 11; i++) begin
		@(posedge clk);
		ps2Data <= bits[i];
		repeat (9) @(posedge clk);
		ps2Clk <= 1'b0;
		repeat (10) @(posedge clk);
		ps2Clk <= 1'b1;
	end
endtask

// Full make or break sequence, swapPrefix flips the E0 rule for this key
task automatic sendKey(input buttonIndex_t idx, input logic isRelease,
		input logic swapPrefix);
	if (isArrow(idx) ^ swapPrefix) begin
		sendFrame(codeExtended, 1'b0);
	end
	if (isRelease) begin
		sendFrame(codeRelease, 1'b0);
	end
	sendFrame(buttonCode(idx), 1'b0);
endtask

// ==== bench/keypadTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module keypadTb;

	import keyPkg::*;

	localparam int clkPeriod   = 40;
	localparam int numRounds   = 16;
	localparam int frameCycles = 11 * 20;
	localparam int satTicks    = int'(holdCountMax) + 10;
	// Per-round worst case of 24 frames, 256 ticks, readback and settling
	localparam int roundCycles = 24 * frameCycles + 256 + 200;
	localparam int limitCycles = 10 + 40 * frameCycles + numRounds * roundCycles
		+ satTicks + 10 * frameCycles + 2000;

	logic                 clk;
	logic                 rst;
	logic                 ps2Clk;
	logic                 ps2Data;
	logic                 holdTick;
	logic                 counterClear;
	buttonIndex_t         readSel;
	holdCount_t           readCount;
	buttonMask_t          heldMask;
	logic                 releaseStrobe;
	buttonIndex_t         releaseIndex;
	holdCount_t           releaseHold;
	errorCount_t          frameErrors;

	// Reference model
	buttonMask_t          modelMask;
	holdCount_t           modelCount [numButtons];
	errorCount_t          modelErrors;
	buttonIndex_t         expIndex [$];
	holdCount_t           expHold [$];

	int                   mismatchCount;
	int                   otherErrors;
	logic [31:0]          lcgState;

	keypadTop UUT (
		.clk           (clk),
		.rst           (rst),
		.ps2Clk        (ps2Clk),
		.ps2Data       (ps2Data),
		.holdTick      (holdTick),
		.counterClear  (counterClear),
		.readSel       (readSel),
		.readCount     (readCount),
		.heldMask      (heldMask),
		.releaseStrobe (releaseStrobe),
		.releaseIndex  (releaseIndex),
		.releaseHold   (releaseHold),
		.frameErrors   (frameErrors)
	);

	`include "ps2KeyStimulus.svh"

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Random numbers and compare tasks
	//////////////////////////////////////////////////

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic int randomBelow(input int n);
		return int'((nextRandom() >> 8) % n);
	endfunction

	task automatic compareCount(input string name, input holdCount_t actual,
			input holdCount_t expected);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s = %0h, expected %0h",
				$time, name, actual, expected);
			mismatchCount++;
		end
	endtask

	task automatic compareMask(input string name, input buttonMask_t actual,
			input buttonMask_t expected);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s = %0h, expected %0h",
				$time, name, actual, expected);
			mismatchCount++;
		end
	endtask

	task automatic compareErrors(input string name, input errorCount_t actual,
			input errorCount_t expected);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s = %0h, expected %0h",
				$time, name, actual, expected);
			mismatchCount++;
		end
	endtask

	task automatic compareIndex(input string name, input buttonIndex_t actual,
			input buttonIndex_t expected);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s = %0h, expected %0h",
				$time, name, actual, expected);
			mismatchCount++;
		end
	endtask

	//////////////////////////////////////////////////
	// Scenario steps with model updates
	//////////////////////////////////////////////////

	// Latency from the last PS/2 edge to the release report
	task automatic settle();
		repeat (8) @(posedge clk);
	endtask

	task automatic pressButton(input buttonIndex_t idx);
		sendKey(idx, 1'b0, 1'b0);
		settle();
		modelMask[idx] = 1'b1;
	endtask

	task automatic releaseButton(input buttonIndex_t idx);
		expIndex.push_back(idx);
		expHold.push_back(modelCount[idx]);
		sendKey(idx, 1'b1, 1'b0);
		settle();
		modelMask[idx] = 1'b0;
	endtask

	// Key sent with the wrong prefix for the DUT to ignore
	task automatic sendSpurious(input buttonIndex_t idx, input logic isRelease);
		sendKey(idx, isRelease, 1'b1);
		settle();
	endtask

	// Bad parity on the make code of an idle plain key
	task automatic sendBadFrame();
		buttonIndex_t target;
		target = modelMask[btnA] ? btnB : btnA;
		sendFrame(buttonCode(target), 1'b1);
		settle();
		if (modelErrors != '1) begin
			modelErrors++;
		end
	endtask

	task automatic applyTicks(input int n);
		int sum;
		for (int k = 0; k < n; k++) begin
			@(posedge clk);
			holdTick <= 1'b1;
		end
		@(posedge clk);
		holdTick <= 1'b0;
		for (int i = 0; i < numButtons; i++) begin
			if (modelMask[i]) begin
				sum = int'(modelCount[i]) + n;
				modelCount[i] = (sum > int'(holdCountMax)) ? holdCountMax : holdCount_t'(sum);
			end
		end
	endtask

	task automatic clearCounts();
		@(posedge clk);
		counterClear <= 1'b1;
		@(posedge clk);
		counterClear <= 1'b0;
		for (int i = 0; i < numButtons; i++) begin
			modelCount[i] = '0;
		end
	endtask

	task automatic checkCounts();
		for (int i = 0; i < numButtons; i++) begin
			@(posedge clk);
			readSel <= buttonIndex_t'(i);
			@(posedge clk);
			@(negedge clk);
			compareCount($sformatf("readCount[%0d]", i), readCount, modelCount[i]);
		end
	endtask

	task automatic checkState();
		@(negedge clk);
		compareMask("heldMask", heldMask, modelMask);
		compareErrors("frameErrors", frameErrors, modelErrors);
	endtask

	// Release reports are checked as they come out
	always @(negedge clk) begin
		if (!rst && releaseStrobe) begin
			if (expIndex.size() == 0) begin
				$display("Release report at %0t with no release sent", $time);
				otherErrors++;
			end else begin
				compareIndex("releaseIndex", releaseIndex, expIndex.pop_front());
				compareCount("releaseHold", releaseHold, expHold.pop_front());
			end
		end
	end

	initial begin
		repeat (limitCycles) @(posedge clk);
		$display("Timeout after %0d cycles, the scenario did not finish", limitCycles);
		$display("SIMULATION FAILED");
		$finish;
	end

	//////////////////////////////////////////////////
	// Main scenario
	//////////////////////////////////////////////////

	initial begin
		buttonIndex_t idx;
		rst           = 1'b1;
		ps2Clk        = 1'b1;
		ps2Data       = 1'b1;
		holdTick      = 1'b0;
		counterClear  = 1'b0;
		readSel       = '0;
		lcgState      = 32'hb0a66741;
		mismatchCount = 0;
		otherErrors   = 0;
		modelMask     = '0;
		modelErrors   = '0;
		for (int i = 0; i < numButtons; i++) begin
			modelCount[i] = '0;
		end
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		checkState();
		checkCounts();

		// Each button once with a short hold
		for (int b = 0; b < numButtons; b++) begin
			pressButton(buttonIndex_t'(b));
			checkState();
			applyTicks(b + 1);
			releaseButton(buttonIndex_t'(b));
			checkState();
		end
		checkCounts();

		for (int r = 0; r < numRounds; r++) begin
			for (int b = 0; b < numButtons; b++) begin
				if (randomBelow(3) == 0) begin
					if (modelMask[b]) begin
						releaseButton(buttonIndex_t'(b));
					end else begin
						pressButton(buttonIndex_t'(b));
					end
				end
			end
			// Held keys get a false release and idle keys a false press
			if (randomBelow(2) == 0) begin
				idx = buttonIndex_t'(randomBelow(numButtons));
				sendSpurious(idx, modelMask[idx]);
			end
			if (randomBelow(3) == 0) begin
				sendBadFrame();
			end
			applyTicks(1 + randomBelow(200));
			checkCounts();
			checkState();
			if (randomBelow(4) == 0) begin
				clearCounts();
				checkCounts();
				checkState();
			end
		end

		// Saturation on one held button
		idx = buttonIndex_t'(randomBelow(numButtons));
		if (!modelMask[idx]) begin
			pressButton(idx);
		end
		clearCounts();
		applyTicks(satTicks);
		checkCounts();
		releaseButton(idx);
		checkState();
		settle();

		if (expIndex.size() != 0) begin
			$display("%0d release reports never arrived", expIndex.size());
			otherErrors++;
		end
		$display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherErrors);
		if (mismatchCount == 0 && otherErrors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+bench
design/keyPkg.sv
design/ps2FrameReceiver.sv
design/scanCodeDecoder.sv
design/holdTimeCounters.sv
design/holdReadout.sv
design/keypadTop.sv
bench/keypadTb.sv

// ==== Bender.yml ====
package:
  name: ps2Keypad

sources:
  - design/keyPkg.sv
  - design/ps2FrameReceiver.sv
  - design/scanCodeDecoder.sv
  - design/holdTimeCounters.sv
  - design/holdReadout.sv
  - design/keypadTop.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/keypadTb.sv
